// File: verilog.f
uart_pkg.sv
byte_fifo.sv
uart_rx_fsm.sv
uart_tx_fsm.sv
uart_top.sv
uart_chk.sv
tb_uart.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_uart -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build error"
   exit 1
fi

./obj_dir/Vtb_uart > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: tb_uart.sv
// UART testbench with a serial driver, a frame monitor and directed tests around uart_top
// Bit edges follow round(8.68 * k) ticks after the start edge
`timescale 1ns/1ns
`default_nettype none

module tb_uart
   import uart_pkg::*;
();

   logic  clk;
   logic  arst_n;
   logic  tick_1us;
   logic  uart_rx;
   logic  uart_tx;
   byte_t tx_data;
   logic  tx_write;
   logic  tx_busy;
   byte_t rx_data;
   logic  rx_valid;
   logic  rx_oflow;
   logic  rx_read;

   int          errors;
   int          test_errors;
   int          tests_run;
   int          tests_bad;
   logic [31:0] rng;

   uart_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // One-clock tick every 4 clocks on the falling edge
   initial begin
      tick_1us = 1'b0;
      forever begin
         repeat (3) @(negedge clk);
         tick_1us = 1'b1;
         @(negedge clk);
         tick_1us = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Tick count from the start edge to edge k of a frame
   function automatic int bit_edge(input int k);
      return (868 * k + 50) / 100;
   endfunction

   task automatic get_random(output byte_t b);
      rng = next_random(rng);
      b   = rng[7:0];
   endtask

   task automatic report_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
      $display("** Error at %0t ns: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
      test_errors++;
   endtask

   task automatic report_text(input string what);
      $display("** Error at %0t ns: %s", $time, what);
      test_errors++;
   endtask

   task automatic abort_timeout(input string what);
      $display("Timeout at %0t ns while waiting for %s", $time, what);
      $display("tests failed");
      $finish;
   endtask

   task automatic finish_test(input string name);
      string verdict;
      verdict = (test_errors == 0) ? "ok" : "FAIL";
      tests_run++;
      if (test_errors != 0) tests_bad++;
      $display("%-20s %s, %0d errors", name, verdict, test_errors);
      errors += test_errors;
      test_errors = 0;
   endtask

   // Returns on the rising edge that carries the n-th tick
   task automatic wait_ticks(input int n);
      int seen;
      int clocks;
      seen   = 0;
      clocks = 0;
      while (seen < n) begin
         @(posedge clk);
         if (tick_1us == 1'b1) seen++;
         clocks++;
         if (clocks > 8 * n + 16) abort_timeout("tick_1us");
      end
   endtask

   task automatic wait_rx_valid();
      int clocks;
      clocks = 0;
      @(negedge clk);
      while (rx_valid !== 1'b1) begin
         @(negedge clk);
         clocks++;
         if (clocks > 400) abort_timeout("rx_valid");
      end
   endtask

   task automatic write_byte(input byte_t b);
      @(negedge clk);
      tx_data  = b;
      tx_write = 1'b1;
      @(negedge clk);
      tx_write = 1'b0;
   endtask

   task automatic pulse_read();
      @(negedge clk);
      rx_read = 1'b1;
      @(negedge clk);
      rx_read = 1'b0;
   endtask

   // Drives one frame on uart_rx with the data LSB first
   task automatic send_serial(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int k = 0; k < 10; k++) begin
         @(negedge clk);
         uart_rx = frame[k];
         wait_ticks(bit_edge(k + 1) - bit_edge(k));
      end
   endtask

   // Samples each uart_tx bit 4 ticks after its predicted edge
   task automatic receive_frame(output byte_t b);
      int clocks;
      int now;
      clocks = 0;
      now    = 0;
      b      = '0;
      @(negedge clk);
      while (uart_tx !== 1'b0) begin
         @(negedge clk);
         clocks++;
         if (clocks > 2000) abort_timeout("start bit on uart_tx");
      end
      for (int k = 0; k < 10; k++) begin
         wait_ticks(bit_edge(k) + 4 - now);
         now = bit_edge(k) + 4;
         @(negedge clk);
         if (k == 0) begin
            if (uart_tx !== 1'b0) report_value("uart_tx start bit", 8'(uart_tx), 8'd0);
         end
         else if (k == 9) begin
            if (uart_tx !== 1'b1) report_value("uart_tx stop bit", 8'(uart_tx), 8'd1);
         end
         else begin
            b[k-1] = uart_tx;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Tests
   // ----------------------------------------------------------------------
   task automatic test_reset();
      arst_n = 1'b0;
      repeat (5) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      if (uart_tx !== 1'b1) report_value("uart_tx", 8'(uart_tx), 8'd1);
      if (tx_busy !== 1'b0) report_value("tx_busy", 8'(tx_busy), 8'd0);
      if (rx_valid !== 1'b0) report_value("rx_valid", 8'(rx_valid), 8'd0);
      if (rx_oflow !== 1'b0) report_value("rx_oflow", 8'(rx_oflow), 8'd0);
      finish_test("reset values");
   endtask

   task automatic test_single_frame();
      byte_t b;
      byte_t got;
      get_random(b);
      fork
         write_byte(b);
         receive_frame(got);
      join
      if (got !== b) report_value("uart_tx frame", got, b);
      // Stop bit still runs after its sample
      wait_ticks(8);
      finish_test("single tx frame");
   endtask

   task automatic test_tx_fifo_full();
      byte_t sent [17];
      byte_t got;
      logic  idle_broken;
      idle_broken = 1'b0;
      for (int i = 0; i < 17; i++) get_random(sent[i]);
      fork
         begin
            for (int i = 0; i < 16; i++) write_byte(sent[i]);
            if (tx_busy !== 1'b1) report_value("tx_busy", 8'(tx_busy), 8'd1);
            // Dropped while full
            write_byte(sent[16]);
         end
         begin
            for (int i = 0; i < 16; i++) begin
               receive_frame(got);
               if (got !== sent[i]) begin
                  report_value($sformatf("uart_tx frame %0d", i), got, sent[i]);
               end
            end
         end
      join
      // A seventeenth frame would start within a few ticks
      for (int t = 0; t < 120; t++) begin
         wait_ticks(1);
         @(negedge clk);
         if (uart_tx !== 1'b1) idle_broken = 1'b1;
      end
      if (idle_broken) report_text("uart_tx left idle after sixteen frames");
      finish_test("tx fifo full");
   endtask

   task automatic test_rx_single();
      byte_t b;
      get_random(b);
      send_serial(b);
      wait_rx_valid();
      if (rx_data !== b) report_value("rx_data", rx_data, b);
      pulse_read();
      if (rx_valid !== 1'b0) report_value("rx_valid", 8'(rx_valid), 8'd0);
      finish_test("single rx byte");
   endtask

   task automatic test_rx_overflow();
      byte_t sent [17];
      for (int i = 0; i < 17; i++) get_random(sent[i]);
      for (int i = 0; i < 17; i++) send_serial(sent[i]);
      wait_rx_valid();
      if (rx_oflow !== 1'b1) report_value("rx_oflow", 8'(rx_oflow), 8'd1);
      // Check the head before each pop
      for (int i = 0; i < 16; i++) begin
         if (rx_valid !== 1'b1) report_value("rx_valid", 8'(rx_valid), 8'd1);
         if (rx_data !== sent[i]) report_value($sformatf("rx_data %0d", i), rx_data, sent[i]);
         pulse_read();
         if ((i == 0) && (rx_oflow !== 1'b0)) report_value("rx_oflow", 8'(rx_oflow), 8'd0);
      end
      if (rx_valid !== 1'b0) report_value("rx_valid", 8'(rx_valid), 8'd0);
      finish_test("rx overflow");
   endtask

   initial begin
      arst_n      = 1'b0;
      uart_rx     = 1'b1;
      tx_data     = '0;
      tx_write    = 1'b0;
      rx_read     = 1'b0;
      errors      = 0;
      test_errors = 0;
      tests_run   = 0;
      tests_bad   = 0;
      rng         = 32'd44910;
      test_reset();
      test_single_frame();
      test_tx_fifo_full();
      test_rx_single();
      test_rx_overflow();
      $display("Summary: %0d tests run, %0d with errors, %0d check errors",
               tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end
      else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: uart_chk.sv
// UART checks bound to uart_top
// Overflow rule, idle line level and known handshake outputs
`timescale 1ns/1ns
`default_nettype none

module uart_chk (
   input logic clk,
   input logic arst_n,
   input logic tx_empty,
   input logic uart_tx,
   input logic tx_busy,
   input logic rx_valid,
   input logic rx_oflow
);

   // Overflow is set only when the receive FIFO is full
   oflow_needs_data: assert property (
      @(posedge clk) disable iff (arst_n == 1'b0) $rose(rx_oflow) |-> rx_valid
   ) else $error("rx_oflow rose while rx_valid was low");

   // Head leaves the FIFO only at the end of stop, so empty means idle line
   idle_line_high: assert property (
      @(posedge clk) disable iff (arst_n == 1'b0) tx_empty |-> uart_tx
   ) else $error("uart_tx low while the transmit FIFO is empty");

   known_flags: assert property (
      @(posedge clk) disable iff (arst_n == 1'b0) !$isunknown({tx_busy, rx_valid})
   ) else $error("tx_busy or rx_valid unknown");

endmodule

bind uart_top uart_chk chk_i (
   .clk      (clk),
   .arst_n   (arst_n),
   .tx_empty (tx_empty),
   .uart_tx  (uart_tx),
   .tx_busy  (tx_busy),
   .rx_valid (rx_valid),
   .rx_oflow (rx_oflow)
);

`default_nettype wire

// File: uart_top.sv
// UART top: transmit and receive FSMs, each with a private 16-entry FIFO
// Software sees plain strobes and levels
`timescale 1ns/1ns
`default_nettype none

module uart_top
   import uart_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  tick_1us,

   // Serial lines
   input  logic  uart_rx,
   output logic  uart_tx,

   // Transmit, a write while busy is dropped
   input  byte_t tx_data,
   input  logic  tx_write,
   output logic  tx_busy,

   // Receive, rx_data holds the FIFO head while rx_valid is high
   output byte_t rx_data,
   output logic  rx_valid,
   output logic  rx_oflow,
   input  logic  rx_read
);

   // ----------------------------------------------------------------------
   // Transmit path
   // ----------------------------------------------------------------------
   byte_t tx_head;
   logic  tx_empty;
   logic  tx_pop;

   // Busy is simply the full flag
   byte_fifo u_tx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (tx_data),
      .we     (tx_write),
      .re     (tx_pop),
      .dout   (tx_head),
      .empty  (tx_empty),
      .full   (tx_busy)
   );

   uart_tx_fsm u_tx (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us),
      .tx_empty (tx_empty),
      .tx_head  (tx_head),
      .tx_pop   (tx_pop),
      .uart_tx  (uart_tx)
   );

   // ----------------------------------------------------------------------
   // Receive path
   // ----------------------------------------------------------------------
   byte_t rx_byte;
   logic  rx_push;
   logic  rx_full;
   logic  rx_empty;

   uart_rx_fsm u_rx (
      .clk      (clk),
      .arst_n   (arst_n),
      .tick_1us (tick_1us),
      .uart_rx  (uart_rx),
      .rx_full  (rx_full),
      .rx_byte  (rx_byte),
      .rx_push  (rx_push),
      .rx_read  (rx_read),
      .rx_oflow (rx_oflow)
   );

   // Read while empty is ignored inside the FIFO
   byte_fifo u_rx_fifo (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (rx_byte),
      .we     (rx_push),
      .re     (rx_read),
      .dout   (rx_data),
      .empty  (rx_empty),
      .full   (rx_full)
   );

   assign rx_valid = ~rx_empty;

endmodule

`default_nettype wire

// File: uart_tx_fsm.sv
// UART transmitter: 8N1 frame generator paced by the 1 us tick
// Sends the transmit FIFO head and pops it when the stop bit ends
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fsm
   import uart_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  tick_1us,

   // Transmit FIFO side
   input  logic  tx_empty,
   input  byte_t tx_head,
   output logic  tx_pop,

   output logic  uart_tx
);

   // ----------------------------------------------------------------------
   // Bit edges after the start edge, in ticks
   //   9, 17, 26, 35, 43, 52, 61, 69, 78, 87
   // Worst edge error is 0.44 us against the 8.68 us ideal grid
   // ----------------------------------------------------------------------

   bit_state_t tx_state;
   bit_state_t tx_next;
   tick_cnt_t  tx_cnt;
   logic       tx_cnt_is0;
   logic       tx_nextbit;
   logic       tx_next_val;

   always_comb begin
      tx_cnt_is0  = (tx_cnt == '0);
      // Current bit ends on this tick
      tx_nextbit  = tick_1us & tx_cnt_is0;
      tx_next     = bit_state_t'(tx_state + 4'd1);

      // Line level for the bit after a data bit, high once STOP is next
      tx_next_val = (tx_next == STOP) ? 1'b1 : tx_head[tx_next[2:0]];

      // Head is done, FIFO may move on
      tx_pop      = tx_nextbit & (tx_state == STOP);
   end

   always_ff @(posedge clk) begin
      if (arst_n == 1'b0) begin
         tx_state <= IDLE;
         tx_cnt   <= '0;
         uart_tx  <= 1'b1;
      end
      else begin
         // Count ticks while a frame is open
         if ((tick_1us == 1'b1) && (tx_state != IDLE)) begin
            tx_cnt <= tick_cnt_t'(tx_cnt - tick_cnt_t'(1));
         end

         unique case (tx_state)
            // Line idles high, leave as soon as there is data
            IDLE: begin
               uart_tx <= 1'b1;
               tx_cnt  <= TX_WAIT_START;
               if (tx_empty == 1'b0) begin
                  tx_state <= START;
               end
            end

            // First tick drives the start bit, aligning the frame to the tick
            START: begin
               if (tick_1us == 1'b1) begin
                  uart_tx <= 1'b0;
                  if (tx_cnt_is0 == 1'b1) begin
                     uart_tx  <= tx_head[0];
                     tx_cnt   <= TX_WAIT[D0];
                     tx_state <= D0;
                  end
               end
            end

            // Hold the stop bit for its full length
            STOP: begin
               if (tx_nextbit == 1'b1) begin
                  tx_state <= IDLE;
               end
            end

            // D0..D7, move to the next bit and load its length
            default: begin
               if (tx_nextbit == 1'b1) begin
                  uart_tx  <= tx_next_val;
                  tx_cnt   <= TX_WAIT[tx_next];
                  tx_state <= tx_next;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: uart_rx_fsm.sv
// UART receiver: tick-paced bit sampler, LSB-first shifter and overflow flag
// Pushes each byte into the receive FIFO at the stop sample
`timescale 1ns/1ns
`default_nettype none

module uart_rx_fsm
   import uart_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  logic  tick_1us,

   input  logic  uart_rx,

   // Receive FIFO side
   input  logic  rx_full,
   output byte_t rx_byte,
   output logic  rx_push,

   // Software side
   input  logic  rx_read,
   output logic  rx_oflow
);

   // ----------------------------------------------------------------------
   // Sample points after the start edge, in ticks
   //   D0 14, D1 22, D2 31, D3 40, D4 48, D5 57, D6 66, D7 74, STOP 83
   // The tick phase adds up to one more, error stays within 1 us of center
   // ----------------------------------------------------------------------

   bit_state_t rx_state;
   bit_state_t rx_next;
   tick_cnt_t  rx_cnt;
   logic       rx_cnt_is0;
   logic       rx_sample;
   byte_t      rx_shift;

   always_comb begin
      rx_cnt_is0 = (rx_cnt == '0);
      // Sample when the wait has run out on a tick
      rx_sample  = tick_1us & rx_cnt_is0;
      // D7 + 1 lands on STOP
      rx_next    = bit_state_t'(rx_state + 4'd1);

      // Byte complete at the stop sample
      rx_push    = rx_sample & (rx_state == STOP);
      rx_byte    = rx_shift;
   end

   // ----------------------------------------------------------------------
   // Control
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (arst_n == 1'b0) begin
         rx_state <= IDLE;
         rx_cnt   <= '0;
         rx_oflow <= 1'b0;
      end
      else begin
         // Count ticks while a frame is open
         if ((tick_1us == 1'b1) && (rx_state != IDLE)) begin
            rx_cnt <= tick_cnt_t'(rx_cnt - tick_cnt_t'(1));
         end

         // Hardware set wins over software clear
         if ((rx_push == 1'b1) && (rx_full == 1'b1)) begin
            rx_oflow <= 1'b1;
         end
         else if (rx_read == 1'b1) begin
            rx_oflow <= 1'b0;
         end

         unique case (rx_state)
            // Wait for the falling edge of the start bit
            IDLE: begin
               rx_cnt <= RX_WAIT_FIRST;
               if (uart_rx == 1'b0) begin
                  // Start bit is skipped, go straight to D0 timing
                  rx_state <= D0;
               end
            end

            // Stop value is not checked
            STOP: begin
               if (rx_sample == 1'b1) begin
                  rx_state <= IDLE;
               end
            end

            // D0..D7, reload the wait for the following sample
            default: begin
               if (rx_sample == 1'b1) begin
                  rx_cnt   <= RX_WAIT[rx_state[2:0]];
                  rx_state <= rx_next;
               end
            end
         endcase
      end
   end

   // Shifter, MSB lands last
   always_ff @(posedge clk) begin
      if ((rx_sample == 1'b1) && (rx_state != IDLE) && (rx_state != STOP)) begin
         rx_shift <= {uart_rx, rx_shift[7:1]};
      end
   end

endmodule

`default_nettype wire

// File: byte_fifo.sv
// Byte FIFO, 16 entries, fall-through head with full and empty flags
// Overflowing writes and underflowing reads are dropped
`timescale 1ns/1ns
`default_nettype none

module byte_fifo
   import uart_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,

   input  byte_t din,
   input  logic  we,
   input  logic  re,

   output byte_t dout,
   output logic  empty,
   output logic  full
);

   // Storage
   byte_t mem [FIFO_DEPTH];

   // Pointers carry one extra wrap bit
   logic [FIFO_AWIDTH:0] wr_ptr;
   logic [FIFO_AWIDTH:0] rd_ptr;

   logic do_write;
   logic do_read;

   // ----------------------------------------------------------------------
   // Flags and qualified strobes
   // ----------------------------------------------------------------------
   always_comb begin
      // Same address, wrap bits tell full from empty
      empty    = (wr_ptr == rd_ptr);
      full     = (wr_ptr[FIFO_AWIDTH] != rd_ptr[FIFO_AWIDTH]) &&
                 (wr_ptr[FIFO_AWIDTH-1:0] == rd_ptr[FIFO_AWIDTH-1:0]);

      do_write = we & ~full;
      do_read  = re & ~empty;

      // Head entry, visible without a read
      dout     = mem[rd_ptr[FIFO_AWIDTH-1:0]];
   end

   // ----------------------------------------------------------------------
   // Pointers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (arst_n == 1'b0) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else begin
         if (do_write == 1'b1) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read == 1'b1) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Data array, no reset
   always_ff @(posedge clk) begin
      if (do_write == 1'b1) begin
         mem[wr_ptr[FIFO_AWIDTH-1:0]] <= din;
      end
   end

endmodule

`default_nettype wire

// File: uart_pkg.sv
// UART shared definitions: frame position, FIFO sizing and bit timing
// Timing is counted in system 1 us ticks, one bit period is 8.68 us
`default_nettype none

package uart_pkg;

   // Frame position, data states hold their own bit index
   typedef enum logic [3:0] {
      D0    = 4'd0,  // LSB goes first
      D1    = 4'd1,
      D2    = 4'd2,
      D3    = 4'd3,
      D4    = 4'd4,
      D5    = 4'd5,
      D6    = 4'd6,
      D7    = 4'd7,  // MSB goes last
      STOP  = 4'd8,  // single stop bit, no parity
      IDLE  = 4'd14,
      START = 4'd15  // used by the transmitter only
   } bit_state_t;

   // Down-counter of 1 us ticks
   typedef logic [3:0] tick_cnt_t;

   // One character, also the FIFO word
   typedef logic [7:0] byte_t;

   // FIFO sizing
   localparam int FIFO_AWIDTH = 4;
   localparam int FIFO_DEPTH  = 16;

   // ---------------------------------------------------------------------
   // Receive sampling, stored values are ticks minus one
   // ---------------------------------------------------------------------
   // 14 ticks from start edge to middle of D0
   localparam tick_cnt_t RX_WAIT_FIRST = 4'd13;
   // Wait after sampling D0..D7, i.e. before D1..D7 and STOP
   localparam tick_cnt_t RX_WAIT [0:7] = '{4'd7, 4'd8, 4'd8, 4'd7,
                                           4'd8, 4'd8, 4'd7, 4'd8};

   // ---------------------------------------------------------------------
   // Transmit bit lengths, stored values are ticks minus one
   // ---------------------------------------------------------------------
   // Start bit, one extra count covers the tick that drives it low
   localparam tick_cnt_t TX_WAIT_START = 4'd9;
   // Length of D0..D7 and STOP, indexed by bit_state_t
   localparam tick_cnt_t TX_WAIT [0:8] = '{4'd7, 4'd8, 4'd8, 4'd7, 4'd8,
                                           4'd8, 4'd7, 4'd8, 4'd8};

endpackage

`default_nettype wire
